// ==== files.f ====
+incdir+verilog
verilog/synth_pkg.sv
verilog/midi_cc_decoder.sv
verilog/midi_ctrl_data.sv
verilog/osc_mixer.sv
verilog/synth_ctrl_top.sv
verif/synth_ctrl_checker.sv
verif/synth_ctrl_tb.sv

// ==== verif/synth_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "synth_defines.svh"

module synth_ctrl_tb
    import synth_pkg::*;
();

    localparam int V = `SYNTH_V_OSC;
    localparam int NROWS = 18;
    localparam logic [1:0] OP_WR = 2'd0;
    localparam logic [1:0] OP_RD = 2'd1;
    localparam logic [1:0] OP_MIX = 2'd2;
    localparam logic [1:0] OP_PIPE = 2'd3;

    typedef struct packed {
        logic [1:0] op;
        logic [3:0] ch;
        logic       bank;
        logic [6:0] adr;
        logic [7:0] val;  // midi data for writes, number of sample sets for mixing
        logic [7:0] exp;
    } row_t;

    logic       reg_clk;
    logic       rst_n;
    logic [7:0] midi_byte;
    logic       byte_valid;
    logic [6:0] rd_adr;
    bank_e      rd_bank;
    logic       read;
    sample_t    osc_sample [V];
    logic       sample_valid;
    ctrl_t      regdata_out;
    sample_t    out_left;
    sample_t    out_right;
    logic       out_valid;
    logic [4:0] cur_midi_ch;
    ctrl_t      mod_out [V];
    ctrl_t      feedb_out [V];
    ctrl_t      mod_in [V];
    ctrl_t      feedb_in [V];
    ctrl_t      model [2][128];  // expected contents of both banks
    sample_t    exp_l [$];
    sample_t    exp_r [$];
    row_t       rows [NROWS];
    int         errors;
    int         timeouts;

    synth_ctrl_top uut (
        .reg_clk       (reg_clk),
        .rst_n         (rst_n),
        .midi_byte     (midi_byte),
        .byte_valid    (byte_valid),
        .rd_adr        (rd_adr),
        .rd_bank       (rd_bank),
        .read          (read),
        .osc_sample    (osc_sample),
        .sample_valid  (sample_valid),
        .regdata_out   (regdata_out),
        .out_left      (out_left),
        .out_right     (out_right),
        .out_valid     (out_valid),
        .cur_midi_ch   (cur_midi_ch),
        .osc_mod_out   (mod_out),
        .osc_feedb_out (feedb_out),
        .osc_mod_in    (mod_in),
        .osc_feedb_in  (feedb_in)
    );

    always #2 reg_clk = ~reg_clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic mapped(input logic b, input logic [6:0] a);
        logic [3:0] off;
        off = a[3:0];
        if (b) begin
            return (a == 7'd1) || (a == 7'd2) || (a >= 7'd16 && a < 7'd32);
        end
        return (a < V * 16) && (off == 2 || off == 3 || off == 4 || off == 7 ||
                                off == 10 || off == 11);
    endfunction

    function automatic sample_t clip(input int v);
        if (v > 32767) begin
            return 16'sh7fff;
        end
        if (v < -32768) begin
            return 16'sh8000;
        end
        return sample_t'(v);
    endfunction

    task automatic model_write(input logic [3:0] ch, input logic b, input logic [6:0] a,
                               input logic [6:0] v);
        logic [4:0] cur;
        cur = model[1][2][4:0];
        if ((cur[4] || ch == cur[3:0]) && mapped(b, a)) begin
            model[b][a] = (b && a == 7'd2) ? {3'b000, v[3:0], 1'b0} : {v, 1'b0};
        end
    endtask

    task automatic send_byte(input logic [7:0] v);
        @(posedge reg_clk);
        midi_byte <= v;
        byte_valid <= 1'b1;
        @(posedge reg_clk);
        byte_valid <= 1'b0;
    endtask

    // status once, then three controllers under running status
    task automatic nrpn_head(input logic [3:0] ch, input logic b, input logic [6:0] a);
        send_byte({4'hB, ch});
        send_byte({1'b0, `SYNTH_CC_NRPN_MSB});
        send_byte({7'd0, b});
        send_byte({1'b0, `SYNTH_CC_NRPN_LSB});
        send_byte({1'b0, a});
        send_byte({1'b0, `SYNTH_CC_DATA});
    endtask

    task automatic nrpn_write(input logic [3:0] ch, input logic b, input logic [6:0] a,
                              input logic [6:0] v);
        nrpn_head(ch, b, a);
        send_byte({1'b0, v});
        model_write(ch, b, a, v);
    endtask

    task automatic read_reg(input logic b, input logic [6:0] a, output logic [7:0] d);
        @(posedge reg_clk);
        rd_adr <= a;
        rd_bank <= bank_e'(b);
        read <= 1'b1;
        @(posedge reg_clk);
        read <= 1'b0;
        @(negedge reg_clk);
        d = regdata_out;
    endtask

    task automatic check_all();
        logic [7:0] d;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 128; a++) begin
                read_reg(b[0], a[6:0], d);
                check({24'h0, d}, {24'h0, model[b][a]}, $sformatf("bank %0d adr %0h", b, a));
            end
        end
        check({27'h0, cur_midi_ch}, {27'h0, model[1][2][4:0]}, "cur_midi_ch port");
        for (int o = 0; o < V; o++) begin
            check({24'h0, mod_out[o]}, {24'h0, model[0][o * 16 + 3]}, "mod_out port");
            check({24'h0, feedb_out[o]}, {24'h0, model[0][o * 16 + 4]}, "feedb_out port");
            check({24'h0, mod_in[o]}, {24'h0, model[0][o * 16 + 10]}, "mod_in port");
            check({24'h0, feedb_in[o]}, {24'h0, model[0][o * 16 + 11]}, "feedb_in port");
        end
    endtask

    // expected mix is taken from the register values the mixer sees at the next edge
    task automatic send_samples();
        int      sum_l;
        int      sum_r;
        int      t;
        int      pan;
        sample_t s;
        sum_l = 0;
        sum_r = 0;
        for (int o = 0; o < V; o++) begin
            s = sample_t'($urandom);
            osc_sample[o] <= s;
            pan = model[0][o * 16 + 7];
            t = (s * model[0][o * 16 + 2]) >>> 6;
            sum_l += (t * (128 - pan)) >>> 7;
            sum_r += (t * pan) >>> 7;
        end
        exp_l.push_back(clip((sum_l * model[1][1]) >>> 6));
        exp_r.push_back(clip((sum_r * model[1][1]) >>> 6));
        sample_valid <= 1'b1;
    endtask

    task automatic drain_mixer();
        int n;
        n = 0;
        while (exp_l.size() != 0 && n < 10) begin
            @(posedge reg_clk);
            n++;
        end
        if (exp_l.size() != 0) begin
            timeouts++;
            $display("timeout: the mixer did not deliver every pending result");
            exp_l.delete();
            exp_r.delete();
        end
    endtask

    task automatic mix_burst(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge reg_clk);
            send_samples();
        end
        @(posedge reg_clk);
        sample_valid <= 1'b0;
        drain_mixer();
    endtask

    // level write lands between two back to back sample sets
    task automatic pipe_level(input logic [3:0] ch, input logic [6:0] a, input logic [6:0] v);
        nrpn_head(ch, 1'b0, a);
        @(posedge reg_clk);
        midi_byte <= {1'b0, v};
        byte_valid <= 1'b1;
        @(posedge reg_clk);
        byte_valid <= 1'b0;
        send_samples();
        @(posedge reg_clk);
        model_write(ch, 1'b0, a, v);
        send_samples();
        @(posedge reg_clk);
        sample_valid <= 1'b0;
        drain_mixer();
    endtask

    always @(negedge reg_clk) begin
        if (rst_n && out_valid) begin
            if (exp_l.size() == 0) begin
                errors++;
                $display("out_valid was raised with no sample set in flight");
            end else begin
                check(out_left, exp_l.pop_front(), "left output");
                check(out_right, exp_r.pop_front(), "right output");
            end
        end
    end

    initial begin
        #100000;
        $display("the simulation did not finish within its time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [7:0] d;
        reg_clk = 1'b0;
        rst_n = 1'b0;
        midi_byte = 8'h00;
        byte_valid = 1'b0;
        rd_adr = 7'd0;
        rd_bank = BANK_OSC;
        read = 1'b0;
        sample_valid = 1'b0;
        for (int o = 0; o < V; o++) begin
            osc_sample[o] = '0;
        end
        errors = 0;
        timeouts = 0;
        void'($urandom(32'h7203abcb));
        for (int a = 0; a < 128; a++) begin
            model[0][a] = 8'h00;
            model[1][a] = (a >= 16 && a < 32) ? 8'h20 : 8'h00;  // patch name fills with spaces
        end
        for (int o = 0; o < V; o++) begin
            model[0][o * 16 + 2] = (o < 2) ? 8'h40 : 8'h00;
            model[0][o * 16 + 7] = 8'h40;
        end
        model[1][1] = 8'h40;

        rows[0]  = {OP_MIX,  4'd0,  1'b0, 7'h00, 8'd2,  8'h00};
        rows[1]  = {OP_WR,   4'd0,  1'b0, 7'h02, 8'h3f, 8'h00};
        rows[2]  = {OP_RD,   4'd0,  1'b0, 7'h02, 8'h00, 8'h7e};
        rows[3]  = {OP_WR,   4'd3,  1'b0, 7'h02, 8'h10, 8'h00};  // wrong channel is ignored
        rows[4]  = {OP_RD,   4'd0,  1'b0, 7'h02, 8'h00, 8'h7e};
        rows[5]  = {OP_WR,   4'd0,  1'b0, 7'h22, 8'h3f, 8'h00};
        rows[6]  = {OP_WR,   4'd0,  1'b0, 7'h32, 8'h3f, 8'h00};
        rows[7]  = {OP_WR,   4'd0,  1'b1, 7'h01, 8'h3f, 8'h00};
        rows[8]  = {OP_RD,   4'd0,  1'b1, 7'h01, 8'h00, 8'h7e};
        rows[9]  = {OP_MIX,  4'd0,  1'b0, 7'h00, 8'd4,  8'h00};  // loud enough to saturate
        rows[10] = {OP_WR,   4'd0,  1'b1, 7'h02, 8'h08, 8'h00};  // channel 16 is omni
        rows[11] = {OP_RD,   4'd0,  1'b1, 7'h02, 8'h00, 8'h10};
        rows[12] = {OP_WR,   4'd9,  1'b0, 7'h17, 8'h30, 8'h00};
        rows[13] = {OP_RD,   4'd0,  1'b0, 7'h17, 8'h00, 8'h60};
        rows[14] = {OP_WR,   4'd14, 1'b0, 7'h12, 8'h28, 8'h00};
        rows[15] = {OP_MIX,  4'd0,  1'b0, 7'h00, 8'd3,  8'h00};
        rows[16] = {OP_PIPE, 4'd5,  1'b0, 7'h02, 8'h08, 8'h00};
        rows[17] = {OP_RD,   4'd0,  1'b0, 7'h02, 8'h00, 8'h10};

        repeat (3) @(posedge reg_clk);
        rst_n <= 1'b1;
        check_all();
        for (int i = 0; i < NROWS; i++) begin
            case (rows[i].op)
                OP_WR: nrpn_write(rows[i].ch, rows[i].bank, rows[i].adr, rows[i].val[6:0]);
                OP_RD: begin
                    read_reg(rows[i].bank, rows[i].adr, d);
                    check({24'h0, d}, {24'h0, rows[i].exp}, $sformatf("row %0d read", i));
                end
                OP_MIX: mix_burst(rows[i].val);
                default: pipe_level(rows[i].ch, rows[i].adr, rows[i].val[6:0]);
            endcase
        end
        for (int a = 0; a < V * 16; a++) begin
            if (mapped(1'b0, a[6:0])) begin
                nrpn_write(a[3:0], 1'b0, a[6:0], 7'(a + 5));
            end
        end
        for (int a = 16; a < 32; a++) begin
            nrpn_write(4'd0, 1'b1, a[6:0], 7'(a * 3));
        end
        check_all();  // every register again, so a stray write shows up

        $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, uut.u_checker.fails);
        if (errors == 0 && timeouts == 0 && uut.u_checker.fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verif/synth_ctrl_checker.sv ====
`timescale 1ns/100ps

module synth_ctrl_checker
    import synth_pkg::*;
(
    input logic  reg_clk,
    input logic  rst_n,
    input logic  sample_valid,
    input logic  out_valid,
    input logic  write,
    input ctrl_t m_vol
);

    int fails = 0;

    a_mix_latency: assert property (@(posedge reg_clk) disable iff (!rst_n)
        sample_valid |-> ##2 out_valid)
        else begin
            fails++;
            $error("out_valid missing two cycles after sample_valid");
        end

    a_write_pulse: assert property (@(posedge reg_clk) disable iff (!rst_n)
        write |=> !write)
        else begin
            fails++;
            $error("write strobe stayed high for more than one cycle");
        end

    // volume must come out of reset at unity
    a_mvol_reset: assert property (@(posedge reg_clk) $rose(rst_n) |-> m_vol == 8'h40)
        else begin
            fails++;
            $error("master volume is not 0x40 after reset");
        end

endmodule

bind synth_ctrl_top synth_ctrl_checker u_checker (
    .reg_clk      (reg_clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .out_valid    (out_valid),
    .write        (write),
    .m_vol        (m_vol)
);

// ==== verilog/synth_ctrl_top.sv ====
`timescale 1ns/100ps
`include "synth_defines.svh"

module synth_ctrl_top
    import synth_pkg::*;
#(
    parameter int V_OSC = `SYNTH_V_OSC
) (
    input  logic       reg_clk,
    input  logic       rst_n,
    input  logic [7:0] midi_byte,
    input  logic       byte_valid,
    input  logic [6:0] rd_adr,
    input  bank_e      rd_bank,
    input  logic       read,
    input  sample_t    osc_sample    [V_OSC],
    input  logic       sample_valid,
    output ctrl_t      regdata_out,
    output sample_t    out_left,
    output sample_t    out_right,
    output logic       out_valid,
    output logic [4:0] cur_midi_ch,
    output ctrl_t      osc_mod_out   [V_OSC],
    output ctrl_t      osc_feedb_out [V_OSC],
    output ctrl_t      osc_mod_in    [V_OSC],
    output ctrl_t      osc_feedb_in  [V_OSC]
);

    logic [6:0] adr;
    bank_e      bank;
    logic       write;
    ctrl_t      synth_data_in;
    ctrl_t      osc_lvl [V_OSC];
    ctrl_t      osc_pan [V_OSC];
    ctrl_t      m_vol;

    midi_cc_decoder u_decoder (
        .reg_clk       (reg_clk),
        .rst_n         (rst_n),
        .midi_byte     (midi_byte),
        .byte_valid    (byte_valid),
        .cur_midi_ch   (cur_midi_ch),
        .adr           (adr),
        .bank          (bank),
        .write         (write),
        .synth_data_in (synth_data_in)
    );

    midi_ctrl_data #(.V_OSC(V_OSC)) u_regs (
        .reg_clk       (reg_clk),
        .rst_n         (rst_n),
        .adr           (adr),
        .bank          (bank),
        .write         (write),
        .synth_data_in (synth_data_in),
        .rd_adr        (rd_adr),
        .rd_bank       (rd_bank),
        .read          (read),
        .regdata_out   (regdata_out),
        .osc_lvl       (osc_lvl),
        .osc_pan       (osc_pan),
        .osc_mod_out   (osc_mod_out),
        .osc_feedb_out (osc_feedb_out),
        .osc_mod_in    (osc_mod_in),
        .osc_feedb_in  (osc_feedb_in),
        .m_vol         (m_vol),
        .cur_midi_ch   (cur_midi_ch)
    );

    osc_mixer #(.V_OSC(V_OSC)) u_mixer (
        .reg_clk      (reg_clk),
        .rst_n        (rst_n),
        .osc_sample   (osc_sample),
        .sample_valid (sample_valid),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .m_vol        (m_vol),
        .out_left     (out_left),
        .out_right    (out_right),
        .out_valid    (out_valid)
    );

endmodule

// ==== verilog/osc_mixer.sv ====
`timescale 1ns/100ps
`include "synth_defines.svh"

module osc_mixer
    import synth_pkg::*;
#(
    parameter int V_OSC = `SYNTH_V_OSC
) (
    input  logic    reg_clk,
    input  logic    rst_n,
    input  sample_t osc_sample [V_OSC],
    input  logic    sample_valid,
    input  ctrl_t   osc_lvl    [V_OSC],
    input  ctrl_t   osc_pan    [V_OSC],
    input  ctrl_t   m_vol,
    output sample_t out_left,
    output sample_t out_right,
    output logic    out_valid
);

    logic signed [23:0] scaled    [V_OSC];
    logic signed [9:0]  gain_l    [V_OSC];
    logic signed [9:0]  gain_r    [V_OSC];
    logic signed [33:0] pan_mul_l [V_OSC];
    logic signed [33:0] pan_mul_r [V_OSC];
    logic signed [19:0] term_l    [V_OSC];
    logic signed [19:0] term_r    [V_OSC];
    ctrl_t              vol_s1;
    logic               s1_valid;
    logic signed [23:0] sum_l;
    logic signed [23:0] sum_r;
    logic signed [31:0] mix_l;
    logic signed [31:0] mix_r;

    function automatic sample_t sat_sample(input logic signed [31:0] v);
        sample_t res;
        if (v > 32'sd32767) begin
            res = 16'sh7fff;
        end else if (v < -32'sd32768) begin
            res = 16'sh8000;
        end else begin
            res = v[15:0];
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < V_OSC; i++) begin
            scaled[i]    = (osc_sample[i] * osc_lvl[i]) >>> 6;
            gain_l[i]    = 10'sd128 - 10'(osc_pan[i]);  // pan 0x40 splits evenly
            gain_r[i]    = 10'(osc_pan[i]);
            pan_mul_l[i] = (scaled[i] * gain_l[i]) >>> 7;
            pan_mul_r[i] = (scaled[i] * gain_r[i]) >>> 7;
        end
    end

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < V_OSC; i++) begin
            sum_l = sum_l + term_l[i];
            sum_r = sum_r + term_r[i];
        end
        mix_l = (sum_l * vol_s1) >>> 6;
        mix_r = (sum_r * vol_s1) >>> 6;
    end

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= sample_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (sample_valid) begin
            for (int i = 0; i < V_OSC; i++) begin
                term_l[i] <= pan_mul_l[i][19:0];
                term_r[i] <= pan_mul_r[i][19:0];
            end
            vol_s1 <= m_vol;  // volume travels with its own sample set
        end
        if (s1_valid) begin
            out_left  <= sat_sample(mix_l);
            out_right <= sat_sample(mix_r);
        end
    end

endmodule

// ==== verilog/midi_ctrl_data.sv ====
`timescale 1ns/100ps
`include "synth_defines.svh"

module midi_ctrl_data
    import synth_pkg::*;
#(
    parameter int V_OSC = `SYNTH_V_OSC
) (
    input  logic       reg_clk,
    input  logic       rst_n,
    input  logic [6:0] adr,
    input  bank_e      bank,
    input  logic       write,
    input  ctrl_t      synth_data_in,
    input  logic [6:0] rd_adr,
    input  bank_e      rd_bank,
    input  logic       read,
    output ctrl_t      regdata_out,
    output ctrl_t      osc_lvl       [V_OSC],
    output ctrl_t      osc_pan       [V_OSC],
    output ctrl_t      osc_mod_out   [V_OSC],
    output ctrl_t      osc_feedb_out [V_OSC],
    output ctrl_t      osc_mod_in    [V_OSC],
    output ctrl_t      osc_feedb_in  [V_OSC],
    output ctrl_t      m_vol,
    output logic [4:0] cur_midi_ch
);

    logic [7:0] patch_name [16];
    ctrl_t      rd_val;
    logic       wr_name;
    logic       rd_name;

    assign wr_name = (adr >= `SYNTH_A_NAME) && (adr < `SYNTH_A_NAME + `SYNTH_NAME_LEN);
    assign rd_name = (rd_adr >= `SYNTH_A_NAME) && (rd_adr < `SYNTH_A_NAME + `SYNTH_NAME_LEN);

    // oscillator n owns addresses 16*n to 16*n+15 in the oscillator bank
    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < V_OSC; i++) begin
                osc_lvl[i]       <= (i < `SYNTH_DEF_LVL_OSCS) ? `SYNTH_DEF_LVL : 8'h00;
                osc_pan[i]       <= `SYNTH_DEF_PAN;
                osc_mod_out[i]   <= '0;
                osc_feedb_out[i] <= '0;
                osc_mod_in[i]    <= '0;
                osc_feedb_in[i]  <= '0;
            end
            for (int n = 0; n < 16; n++) begin
                patch_name[n] <= `SYNTH_DEF_NAME;
            end
            m_vol       <= `SYNTH_DEF_MVOL;
            cur_midi_ch <= `SYNTH_DEF_MIDI_CH;
        end else if (write) begin
            if (bank == BANK_OSC) begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (adr[6:4] == 3'(i)) begin
                        case (adr[3:0])
                            `SYNTH_A_LVL:       osc_lvl[i]       <= synth_data_in;
                            `SYNTH_A_MOD_OUT:   osc_mod_out[i]   <= synth_data_in;
                            `SYNTH_A_FEEDB_OUT: osc_feedb_out[i] <= synth_data_in;
                            `SYNTH_A_PAN:       osc_pan[i]       <= synth_data_in;
                            `SYNTH_A_MOD_IN:    osc_mod_in[i]    <= synth_data_in;
                            `SYNTH_A_FEEDB_IN:  osc_feedb_in[i]  <= synth_data_in;
                            default: begin
                            end
                        endcase
                    end
                end
            end else begin
                if (adr == `SYNTH_A_MVOL) begin
                    m_vol <= synth_data_in;
                end else if (adr == `SYNTH_A_MIDI_CH) begin
                    cur_midi_ch <= synth_data_in[4:0];
                end else if (wr_name) begin
                    patch_name[adr[3:0]] <= synth_data_in;
                end
            end
        end
    end

    always_comb begin
        rd_val = '0;  // unmapped addresses read back as zero
        if (rd_bank == BANK_OSC) begin
            for (int i = 0; i < V_OSC; i++) begin
                if (rd_adr[6:4] == 3'(i)) begin
                    case (rd_adr[3:0])
                        `SYNTH_A_LVL:       rd_val = osc_lvl[i];
                        `SYNTH_A_MOD_OUT:   rd_val = osc_mod_out[i];
                        `SYNTH_A_FEEDB_OUT: rd_val = osc_feedb_out[i];
                        `SYNTH_A_PAN:       rd_val = osc_pan[i];
                        `SYNTH_A_MOD_IN:    rd_val = osc_mod_in[i];
                        `SYNTH_A_FEEDB_IN:  rd_val = osc_feedb_in[i];
                        default: begin
                        end
                    endcase
                end
            end
        end else begin
            if (rd_adr == `SYNTH_A_MVOL) begin
                rd_val = m_vol;
            end else if (rd_adr == `SYNTH_A_MIDI_CH) begin
                rd_val = {3'b000, cur_midi_ch};
            end else if (rd_name) begin
                rd_val = patch_name[rd_adr[3:0]];
            end
        end
    end

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            regdata_out <= '0;
        end else if (read) begin
            regdata_out <= rd_val;  // held until the host reads again
        end
    end

endmodule

// ==== verilog/midi_cc_decoder.sv ====
`timescale 1ns/100ps
`include "synth_defines.svh"

module midi_cc_decoder
    import synth_pkg::*;
(
    input  logic       reg_clk,
    input  logic       rst_n,
    input  logic [7:0] midi_byte,
    input  logic       byte_valid,
    input  logic [4:0] cur_midi_ch,
    output logic [6:0] adr,
    output bank_e      bank,
    output logic       write,
    output ctrl_t      synth_data_in
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CTRL,
        ST_VALUE
    } dec_state_e;

    dec_state_e state;
    logic [6:0] cc_num;
    logic       is_status;
    logic       ch_match;
    logic       cc_status;

    assign is_status = midi_byte[7];
    assign ch_match  = cur_midi_ch[4] || (midi_byte[3:0] == cur_midi_ch[3:0]);  // 16 and up is omni
    assign cc_status = (midi_byte[7:4] == 4'hB) && ch_match;

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            write <= 1'b0;
            adr   <= '0;
            bank  <= BANK_OSC;
        end else begin
            write <= 1'b0;
            if (byte_valid) begin
                if (is_status) begin
                    state <= cc_status ? ST_CTRL : ST_IDLE;  // any other status drops running status
                end else begin
                    case (state)
                        ST_CTRL: begin
                            state <= ST_VALUE;
                        end
                        ST_VALUE: begin
                            state <= ST_CTRL;  // stay open for the next controller under running status
                            case (cc_num)
                                `SYNTH_CC_NRPN_MSB: begin
                                    bank <= bank_e'(midi_byte[0]);
                                end
                                `SYNTH_CC_NRPN_LSB: begin
                                    adr <= midi_byte[6:0];
                                end
                                `SYNTH_CC_DATA: begin
                                    write <= 1'b1;
                                end
                                default: begin
                                end
                            endcase
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (byte_valid && !is_status) begin
            if (state == ST_CTRL) begin
                cc_num <= midi_byte[6:0];
            end
            if (state == ST_VALUE && cc_num == `SYNTH_CC_DATA) begin
                synth_data_in <= {midi_byte[6:0], 1'b0};  // 7-bit data scaled up to the register range
            end
        end
    end

endmodule

// ==== verilog/synth_pkg.sv ====
package synth_pkg;

    typedef logic signed [15:0] sample_t;   // audio sample on the oscillator and mixer side

    typedef logic signed [7:0] ctrl_t;      // 0x40 stands for unity gain or centre pan

    typedef enum logic {
        BANK_OSC = 1'b0,
        BANK_COM = 1'b1
    } bank_e;

endpackage

// ==== verilog/synth_defines.svh ====
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

`define SYNTH_V_OSC         4       // oscillators per voice, 2 to 8 supported

`define SYNTH_A_LVL         4'd2
`define SYNTH_A_MOD_OUT     4'd3
`define SYNTH_A_FEEDB_OUT   4'd4
`define SYNTH_A_PAN         4'd7
`define SYNTH_A_MOD_IN      4'd10
`define SYNTH_A_FEEDB_IN    4'd11

`define SYNTH_A_MVOL        7'd1
`define SYNTH_A_MIDI_CH     7'd2
`define SYNTH_A_NAME        7'd16   // patch name occupies 16 bytes from here
`define SYNTH_NAME_LEN      7'd16

`define SYNTH_CC_NRPN_MSB   7'd99
`define SYNTH_CC_NRPN_LSB   7'd98
`define SYNTH_CC_DATA       7'd6

`define SYNTH_DEF_LVL       8'h40
`define SYNTH_DEF_LVL_OSCS  2       // oscillators that come out of reset at unity level
`define SYNTH_DEF_PAN       8'h40
`define SYNTH_DEF_MVOL      8'h40
`define SYNTH_DEF_MIDI_CH   5'd0
`define SYNTH_DEF_NAME      8'h20

`endif
